// File: Makefile
# Verilator build and run for the register access testbench
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_hv_reg_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
SIM_ARGS  ?=
PASS_LINE ?= Simulation PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# the run passes only when the output holds the pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_LINE)"

clean:
	rm -rf $(OBJ_DIR)

// File: include/hv_defines.svh
// ======================================================================
// shared widths, register bank depth and CRC polynomial for the
// register access subsystem
// ======================================================================
`ifndef HV_DEFINES_SVH
`define HV_DEFINES_SVH

// register address and data widths
`define HV_REG_AW       7
`define HV_REG_DW       8

// write CRC width
`define HV_REG_CRC_W    8

// full address space, top address holds the CRC error counter
`define HV_REG_DEPTH    128
`define HV_ERR_CNT_ADDR 7'h7F

// CRC-8, MSB first, zero initial value
`define HV_CRC_POLY     8'h07

`endif

// File: rtl/hv_crc8.sv
// ======================================================================
// parallel CRC-8 over one 16-bit address/data word
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "hv_defines.svh"

module hv_crc8 (
    input  wire logic [15:0]                i_word,
    output logic      [`HV_REG_CRC_W-1:0]   o_crc
);

    // running remainder and feedback bit
    logic [`HV_REG_CRC_W-1:0] crc_v;
    logic                     fb;

    // ======================================================================
    // bit-serial recurrence, fully unrolled by the loop
    // ======================================================================
    always_comb begin
        crc_v = '0;
        fb    = 1'b0;
        // msb of the word enters first
        for (int i = 15; i >= 0; i--) begin
            fb    = crc_v[`HV_REG_CRC_W-1] ^ i_word[i];
            crc_v = {crc_v[`HV_REG_CRC_W-2:0], 1'b0};
            if (fb) begin
                crc_v = crc_v ^ `HV_CRC_POLY;
            end
        end
    end

    assign o_crc = crc_v;

endmodule

`default_nettype wire

// File: rtl/hv_owt_pkg.sv
// ======================================================================
// one-wire downlink frame struct
// ======================================================================
`default_nettype none

package hv_owt_pkg;

    // decoded downlink frame, always a write
    typedef struct packed {
        // bit 7 unused, register address in 6:0
        logic [7:0] addr;
        logic [7:0] data;
    } owt_frame_t;

endpackage

`default_nettype wire

// File: rtl/hv_reg_acc_ctrl.sv
// ======================================================================
// register access controller: write CRC check, 127-byte register
// bank, read-back and saturating CRC error counter
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "hv_defines.svh"

module hv_reg_acc_ctrl (
    input  wire logic                   i_clk,
    input  wire logic                   i_rst_n,
    input  wire hv_reg_pkg::reg_req_t   i_req,
    output hv_reg_pkg::reg_rsp_t        o_rsp
);

    import hv_reg_pkg::*;

    // bank covers every address below the counter
    localparam int BANK_N = `HV_REG_DEPTH - 1;

    logic [`HV_REG_DW-1:0]      bank [BANK_N];
    logic [`HV_REG_DW-1:0]      err_cnt;
    reg_rsp_t                   rsp_q;

    // ack still high, request from last cycle not retaken
    logic                       ack_busy;
    logic                       accept;
    logic                       wr_acc;
    logic                       rd_acc;
    logic                       is_cnt_addr;

    // crc check of the incoming write
    logic [15:0]                chk_word;
    logic [`HV_REG_CRC_W-1:0]   chk_crc;
    logic                       crc_ok;

    logic [`HV_REG_DW-1:0]      rd_data;

    assign ack_busy    = rsp_q.wack | rsp_q.rack;
    assign accept      = (i_req.wr_req | i_req.rd_req) & ~ack_busy;
    assign wr_acc      = accept & i_req.wr_req;
    assign rd_acc      = accept & i_req.rd_req;
    assign is_cnt_addr = (i_req.addr == `HV_ERR_CNT_ADDR);

    // ======================================================================
    // crc check
    // ======================================================================
    assign chk_word = {1'b0, i_req.addr, i_req.wdata};

    hv_crc8 u_crc_chk (
        .i_word (chk_word),
        .o_crc  (chk_crc)
    );

    assign crc_ok = (chk_crc == i_req.wcrc);

    // ======================================================================
    // register bank
    // ======================================================================
    // good write, counter address is read-only
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < BANK_N; i++) begin
                bank[i] <= '0;
            end
        end else if (wr_acc && crc_ok && !is_cnt_addr) begin
            bank[i_req.addr] <= i_req.wdata;
        end
    end

    // bad write bumps the counter, stops at 255
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            err_cnt <= '0;
        end else if (wr_acc && !crc_ok && (err_cnt != '1)) begin
            err_cnt <= err_cnt + 1'b1;
        end
    end

    // ======================================================================
    // acknowledge
    // ======================================================================
    // counter sits at the top address
    assign rd_data = is_cnt_addr ? err_cnt : bank[i_req.addr];

    // one-cycle ack after the accepting edge
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rsp_q <= '0;
        end else if (accept) begin
            rsp_q.wack <= i_req.wr_req;
            rsp_q.rack <= i_req.rd_req;
            rsp_q.data <= rd_acc ? rd_data : '0;
            rsp_q.addr <= i_req.addr;
        end else begin
            rsp_q <= '0;
        end
    end

    assign o_rsp = rsp_q;

endmodule

`default_nettype wire

// File: rtl/hv_reg_pkg.sv
// ======================================================================
// register access request and response structs
// ======================================================================
`default_nettype none

`include "hv_defines.svh"

package hv_reg_pkg;

    // request toward the register access controller
    typedef struct packed {
        logic                       wr_req;
        logic                       rd_req;
        logic [`HV_REG_AW-1:0]      addr;
        logic [`HV_REG_DW-1:0]      wdata;
        logic [`HV_REG_CRC_W-1:0]   wcrc;
    } reg_req_t;

    // one-cycle acknowledge back to the host
    typedef struct packed {
        logic                       wack;
        logic                       rack;
        // read data, zero on write ack
        logic [`HV_REG_DW-1:0]      data;
        // echo of the request address
        logic [`HV_REG_AW-1:0]      addr;
    } reg_rsp_t;

endpackage

`default_nettype wire

// File: rtl/hv_reg_top.sv
// ======================================================================
// register access top: SPI/OWT arbiter feeding the access controller
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module hv_reg_top (
    input  wire logic                       i_clk,
    input  wire logic                       i_rst_n,

    // spi side
    input  wire hv_reg_pkg::reg_req_t       i_spi_req,
    output hv_reg_pkg::reg_rsp_t            o_spi_rsp,

    // owt side
    input  wire logic                       i_owt_vld,
    input  wire hv_owt_pkg::owt_frame_t     i_owt_frame,
    output logic                            o_owt_rdy
);

    import hv_reg_pkg::*;

    // arbiter to rac
    reg_req_t rac_req;
    reg_rsp_t rac_rsp;

    hv_spi_owt_acc_arb u_arb (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_spi_req   (i_spi_req),
        .o_spi_rsp   (o_spi_rsp),
        .i_owt_vld   (i_owt_vld),
        .i_owt_frame (i_owt_frame),
        .o_owt_rdy   (o_owt_rdy),
        .o_rac_req   (rac_req),
        .i_rac_rsp   (rac_rsp)
    );

    hv_reg_acc_ctrl u_rac (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_req   (rac_req),
        .o_rsp   (rac_rsp)
    );

endmodule

`default_nettype wire

// File: rtl/hv_spi_owt_acc_arb.sv
// ======================================================================
// SPI / OWT access arbiter in front of the register access controller
// grant flag, request and response steering, CRC for OWT writes
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "hv_defines.svh"

module hv_spi_owt_acc_arb (
    input  wire logic                       i_clk,
    input  wire logic                       i_rst_n,

    // SPI register master, held until ack
    input  wire hv_reg_pkg::reg_req_t       i_spi_req,
    output hv_reg_pkg::reg_rsp_t            o_spi_rsp,

    // OWT downlink frames, valid/ready
    input  wire logic                       i_owt_vld,
    input  wire hv_owt_pkg::owt_frame_t     i_owt_frame,
    output logic                            o_owt_rdy,

    // toward the RAC
    output hv_reg_pkg::reg_req_t            o_rac_req,
    input  wire hv_reg_pkg::reg_rsp_t       i_rac_rsp
);

    import hv_reg_pkg::*;

    // 0 = owt, 1 = spi
    logic                       grant_spi;
    // spi host raising any request
    logic                       spi_req_any;
    // granted side still busy
    logic                       spi_act;
    logic                       owt_act;
    // crc over the owt frame
    logic [15:0]                owt_crc_word;
    logic [`HV_REG_CRC_W-1:0]   owt_crc;
    // owt frame expressed as a register request
    reg_req_t                   owt_req;

    assign spi_req_any = i_spi_req.wr_req | i_spi_req.rd_req;
    assign spi_act     = spi_req_any & grant_spi;
    assign owt_act     = i_owt_vld & ~grant_spi;

    // ======================================================================
    // grant flag
    // ======================================================================
    // owt wins when spi is not mid-transfer, spi takes over when owt idles
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            grant_spi <= 1'b0;
        end else if (i_owt_vld && !spi_act) begin
            grant_spi <= 1'b0;
        end else if (spi_req_any && !owt_act) begin
            grant_spi <= 1'b1;
        end
    end

    // ======================================================================
    // owt request build
    // ======================================================================
    // frame has no crc, generate it here
    assign owt_crc_word = {1'b0, i_owt_frame.addr[`HV_REG_AW-1:0], i_owt_frame.data};

    hv_crc8 u_crc_owt (
        .i_word (owt_crc_word),
        .o_crc  (owt_crc)
    );

    // top address bit dropped, always a write
    assign owt_req.wr_req = i_owt_vld;
    assign owt_req.rd_req = 1'b0;
    assign owt_req.addr   = i_owt_frame.addr[`HV_REG_AW-1:0];
    assign owt_req.wdata  = i_owt_frame.data;
    assign owt_req.wcrc   = owt_crc;

    // ======================================================================
    // steering
    // ======================================================================
    assign o_rac_req = grant_spi ? i_spi_req : owt_req;

    // only the granted side sees the response
    assign o_spi_rsp = grant_spi ? i_rac_rsp : '0;
    assign o_owt_rdy = ~grant_spi & i_rac_rsp.wack;

endmodule

`default_nettype wire

// File: src.f
+incdir+include
rtl/hv_reg_pkg.sv
rtl/hv_owt_pkg.sv
rtl/hv_crc8.sv
rtl/hv_spi_owt_acc_arb.sv
rtl/hv_reg_acc_ctrl.sv
rtl/hv_reg_top.sv
verif/tb_hv_reg_top.sv

// File: verif/tb_hv_reg_top.sv
// ======================================================================
// testbench for the register access top with random SPI and OWT hosts,
// a byte-level reference model, compare tasks and a watchdog
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "hv_defines.svh"

module tb_hv_reg_top;

    import hv_reg_pkg::*;
    import hv_owt_pkg::*;

    localparam int          CLK_PERIOD = 40;
    localparam int          RST_CYCLES = 16;
    localparam logic [31:0] RNG_SEED   = 32'h5d4bba07;

    // operation counts per phase
    localparam int N_INIT_RD = 16;
    localparam int N_SPI_OPS = 200;
    localparam int N_OWT_OPS = 150;
    localparam int N_SAT_WR  = 280;
    localparam int N_SWEEP   = `HV_REG_DEPTH;
    localparam int N_TOTAL   = N_INIT_RD + N_SPI_OPS + N_OWT_OPS + N_SAT_WR + N_SWEEP + 16;
    // idle gap, wait behind the other host, accept, ack and block
    localparam int CYC_PER_OP = 16;
    localparam longint WATCHDOG_NS = 2 * (RST_CYCLES + N_TOTAL * CYC_PER_OP) * CLK_PERIOD;

    logic       clk;
    logic       rst_n;
    reg_req_t   spi_req;
    reg_rsp_t   spi_rsp;
    logic       owt_vld;
    owt_frame_t owt_frame;
    logic       owt_rdy;

    // reference model with the top entry mirrored by model_cnt
    logic [`HV_REG_DW-1:0] model_bank [`HV_REG_DEPTH];
    logic [`HV_REG_DW-1:0] model_cnt;

    // acks seen on the outputs vs. completions seen by the hosts
    int spi_ack_seen = 0;
    int owt_ack_seen = 0;
    int spi_done     = 0;
    int owt_done     = 0;
    int seed_val;

    hv_reg_top dut0 (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_spi_req   (spi_req),
        .o_spi_rsp   (spi_rsp),
        .i_owt_vld   (owt_vld),
        .i_owt_frame (owt_frame),
        .o_owt_rdy   (owt_rdy)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ======================================================================
    // failure reporting and compare tasks
    // ======================================================================
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_spi_read(input reg_rsp_t rsp, input logic [`HV_REG_AW-1:0] addr,
                                  input logic [`HV_REG_DW-1:0] exp);
        if (rsp.rack !== 1'b1 || rsp.wack !== 1'b0) begin
            fail_run($sformatf("** Error @ %0t ns: SPI read %02h acked with wack=%b rack=%b",
                               $time, addr, rsp.wack, rsp.rack));
        end
        if (rsp.addr !== addr) begin
            fail_run($sformatf("** Error @ %0t ns: SPI read echoed addr %02h, expected %02h",
                               $time, rsp.addr, addr));
        end
        if (rsp.data !== exp) begin
            fail_run($sformatf("** Error @ %0t ns: SPI read %02h returned %02h, expected %02h",
                               $time, addr, rsp.data, exp));
        end
    endtask

    task automatic check_spi_write(input reg_rsp_t rsp, input logic [`HV_REG_AW-1:0] addr);
        if (rsp.wack !== 1'b1 || rsp.rack !== 1'b0) begin
            fail_run($sformatf("** Error @ %0t ns: SPI write %02h acked with wack=%b rack=%b",
                               $time, addr, rsp.wack, rsp.rack));
        end
        if (rsp.addr !== addr || rsp.data !== '0) begin
            fail_run($sformatf("** Error @ %0t ns: SPI write ack addr %02h data %02h, exp %02h/00",
                               $time, rsp.addr, rsp.data, addr));
        end
    endtask

    task automatic check_owt_done(input owt_frame_t frame, input logic rdy,
                                  input reg_rsp_t spi_side);
        if (rdy !== 1'b1) begin
            fail_run($sformatf("** Error @ %0t ns: OWT frame %02h/%02h ended without ready",
                               $time, frame.addr, frame.data));
        end
        // SPI side must stay quiet while OWT owns the RAC
        if (spi_side.wack !== 1'b0 || spi_side.rack !== 1'b0) begin
            fail_run($sformatf("** Error @ %0t ns: SPI ack during OWT frame %02h/%02h",
                               $time, frame.addr, frame.data));
        end
    endtask

    // ======================================================================
    // reference model
    // ======================================================================
    // long division of {0, addr, data, 8'h00} by x^8 + poly
    function automatic logic [`HV_REG_CRC_W-1:0] calc_crc(input logic [`HV_REG_AW-1:0] addr,
                                                          input logic [`HV_REG_DW-1:0] data);
        logic [23:0] rem;
        rem = {1'b0, addr, data, 8'h00};
        for (int b = 23; b >= 8; b--) begin
            if (rem[b]) begin
                rem[b -: 9] = rem[b -: 9] ^ {1'b1, `HV_CRC_POLY};
            end
        end
        return rem[7:0];
    endfunction

    // bad crc bumps the counter and a good write skips the counter address
    task automatic model_write(input logic [`HV_REG_AW-1:0] addr,
                               input logic [`HV_REG_DW-1:0] data, input logic crc_good);
        if (!crc_good) begin
            if (model_cnt != 8'hFF) begin
                model_cnt = model_cnt + 8'd1;
            end
        end else if (addr != `HV_ERR_CNT_ADDR) begin
            model_bank[addr] = data;
        end
    endtask

    function automatic logic [`HV_REG_DW-1:0] model_read(input logic [`HV_REG_AW-1:0] addr);
        return (addr == `HV_ERR_CNT_ADDR) ? model_cnt : model_bank[addr];
    endfunction

    // counter address gets extra weight
    function automatic logic [`HV_REG_AW-1:0] pick_addr();
        if ($urandom_range(0, 7) == 0) begin
            return `HV_ERR_CNT_ADDR;
        end
        return 7'($urandom_range(0, 126));
    endfunction

    // ======================================================================
    // host tasks entered and left on a falling edge
    // ======================================================================
    task automatic spi_access(input logic wr, input logic [`HV_REG_AW-1:0] addr,
                              input logic [`HV_REG_DW-1:0] data, input logic bad_crc);
        reg_req_t              req;
        reg_rsp_t              rsp;
        logic [`HV_REG_DW-1:0] exp;
        req.wr_req = wr;
        req.rd_req = ~wr;
        req.addr   = addr;
        req.wdata  = wr ? data : '0;
        req.wcrc   = calc_crc(addr, req.wdata);
        // corrupt with a nonzero mask
        if (bad_crc) begin
            req.wcrc = req.wcrc ^ 8'($urandom_range(1, 255));
        end
        spi_req = req;
        // held until an ack shows on a falling edge
        rsp = '0;
        while (!(rsp.wack || rsp.rack)) begin
            @(negedge clk);
            rsp = spi_rsp;
        end
        spi_req = '0;
        spi_done++;
        if (wr) begin
            check_spi_write(rsp, addr);
            model_write(addr, data, !bad_crc);
        end else begin
            exp = model_read(addr);
            check_spi_read(rsp, addr, exp);
        end
    endtask

    task automatic owt_write(input owt_frame_t frame);
        logic     rdy;
        reg_rsp_t spi_side;
        owt_frame = frame;
        owt_vld   = 1'b1;
        rdy       = 1'b0;
        spi_side  = '0;
        while (!rdy) begin
            @(negedge clk);
            rdy      = owt_rdy;
            spi_side = spi_rsp;
        end
        owt_vld   = 1'b0;
        owt_frame = '0;
        owt_done++;
        check_owt_done(frame, rdy, spi_side);
        // arbiter supplies the crc and the top address bit is ignored
        model_write(frame.addr[`HV_REG_AW-1:0], frame.data, 1'b1);
    endtask

    // reads, good writes and bad-crc writes in a 4:4:2 mix
    task automatic run_spi_host(input int n_ops);
        int                    kind;
        logic [`HV_REG_AW-1:0] addr;
        logic [`HV_REG_DW-1:0] data;
        for (int i = 0; i < n_ops; i++) begin
            repeat ($urandom_range(1, 4)) @(negedge clk);
            kind = $urandom_range(0, 9);
            addr = pick_addr();
            data = 8'($urandom);
            if (kind < 4) begin
                spi_access(1'b0, addr, '0, 1'b0);
            end else begin
                spi_access(1'b1, addr, data, kind >= 8);
            end
        end
    endtask

    task automatic run_owt_host(input int n_ops);
        owt_frame_t frame;
        for (int i = 0; i < n_ops; i++) begin
            repeat ($urandom_range(1, 4)) @(negedge clk);
            frame.addr = 8'($urandom);
            frame.data = 8'($urandom);
            if ($urandom_range(0, 7) == 0) begin
                frame.addr[`HV_REG_AW-1:0] = `HV_ERR_CNT_ADDR;
            end
            owt_write(frame);
        end
    endtask

    // ======================================================================
    // ack monitor and watchdog
    // ======================================================================
    // one ack at most per cycle and never on both sides
    always @(negedge clk) begin
        if (rst_n) begin
            if (spi_rsp.wack && spi_rsp.rack) begin
                fail_run($sformatf("** Error @ %0t ns: SPI wack and rack both high", $time));
            end
            if (owt_rdy && (spi_rsp.wack || spi_rsp.rack)) begin
                fail_run($sformatf("** Error @ %0t ns: SPI and OWT acked together", $time));
            end
            if (spi_rsp.wack || spi_rsp.rack) begin
                spi_ack_seen++;
            end
            if (owt_rdy) begin
                owt_ack_seen++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run("watchdog expired, the run timed out before all operations completed");
    end

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        seed_val  = $urandom(RNG_SEED);
        rst_n     = 1'b0;
        spi_req   = '0;
        owt_vld   = 1'b0;
        owt_frame = '0;
        for (int a = 0; a < `HV_REG_DEPTH; a++) begin
            model_bank[a] = '0;
        end
        model_cnt = '0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // everything reads zero after reset with the counter first
        for (int i = 0; i < N_INIT_RD; i++) begin
            spi_access(1'b0, (i == 0) ? `HV_ERR_CNT_ADDR : pick_addr(), '0, 1'b0);
        end

        // both hosts racing for the RAC
        fork
            run_spi_host(N_SPI_OPS);
            run_owt_host(N_OWT_OPS);
        join

        // drive the counter into saturation back to back
        for (int i = 0; i < N_SAT_WR; i++) begin
            spi_access(1'b1, pick_addr(), 8'($urandom), 1'b1);
            if (i % 40 == 39) begin
                spi_access(1'b0, `HV_ERR_CNT_ADDR, '0, 1'b0);
            end
        end
        // good write to the counter address must not stick
        spi_access(1'b1, `HV_ERR_CNT_ADDR, 8'h5A, 1'b0);

        // full read-back against the model
        for (int a = 0; a < N_SWEEP; a++) begin
            spi_access(1'b0, 7'(a), '0, 1'b0);
        end

        // let the monitor see the last ack and any stray one
        repeat (2) @(negedge clk);
        if (spi_ack_seen != spi_done || owt_ack_seen != owt_done) begin
            fail_run($sformatf("ack count mismatch: spi %0d/%0d, owt %0d/%0d",
                               spi_ack_seen, spi_done, owt_ack_seen, owt_done));
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
